// ==== hdl/bridge_pkg.sv ====
// Widths, PCX/CPX field positions and encodings shared by every block of the core to Wishbone bridge
package bridge_pkg;

  // Packet and bus widths
  localparam int pcx_width     = 124;
  localparam int cpx_width     = 145;
  localparam int wb_addr_width = 64;
  localparam int wb_data_width = 64;
  localparam int wb_sel_width  = 8;
  localparam int irq_width     = 6;

  // One-hot target region, bits 0 to 3 are RAM banks
  localparam int region_width = 5;
  localparam logic [region_width-1:0] io_region = 5'b10000;  // I/O block

  // PCX request packet fields
  localparam int pcx_vld_bit = 123;
  localparam int pcx_rq_hi   = 122;
  localparam int pcx_rq_lo   = 118;
  localparam int pcx_r_bit   = 117;  // Read-not-write, or NC for IMISS
  localparam int pcx_th_hi   = 113;
  localparam int pcx_th_lo   = 112;
  localparam int pcx_sz_hi   = 106;
  localparam int pcx_sz_lo   = 104;
  localparam int pcx_ad_hi   = 103;
  localparam int pcx_ad_lo   = 64;
  localparam int pcx_da_hi   = 63;
  localparam int pcx_da_lo   = 0;
  localparam int pcx_ad_top  = pcx_ad_hi - pcx_ad_lo;  // Top index of the 40-bit address

  // Wishbone address build
  localparam int addr_pad_width = 19;                 // Zeros between region and address
  localparam logic [3:0] beat2_offset = 4'b1000;      // Upper doubleword of a quadword

  // Byte select patterns, shifted into place by address
  localparam logic [wb_sel_width-1:0] sel_byte = 8'h01;
  localparam logic [wb_sel_width-1:0] sel_half = 8'h03;
  localparam logic [wb_sel_width-1:0] sel_word = 8'h0f;
  localparam logic [wb_sel_width-1:0] sel_all  = 8'hff;

  // Reset type carried by the wakeup packet
  localparam logic [irq_width-1:0] wakeup_reset_type = 6'b000001;

  typedef enum logic [4:0] {
    LOAD_RQ  = 5'b00000,
    STORE_RQ = 5'b00001,
    IMISS_RQ = 5'b10000
  } pcx_rq_e;

  typedef enum logic [2:0] {
    SZ_1B  = 3'b000,
    SZ_2B  = 3'b001,
    SZ_4B  = 3'b010,
    SZ_8B  = 3'b011,
    SZ_16B = 3'b111
  } pcx_size_e;

  typedef enum logic [3:0] {
    LOAD_RET  = 4'b0000,
    IFILL_RET = 4'b0001,
    ST_ACK    = 4'b0100,
    INT_RET   = 4'b0111
  } cpx_rq_e;

  // Which return packet the builder presents
  typedef enum logic [1:0] {
    PKT_NONE,
    PKT_WAKEUP,
    PKT_INT,
    PKT_DATA
  } pkt_kind_e;

  typedef enum logic [3:0] {
    WAKEUP,
    IDLE,
    REQ_LATCHED,
    PKT_LATCHED,
    ACCESS1_WAIT,
    ACCESS2_ISSUE,
    ACCESS2_WAIT,
    PKT_READY
  } bridge_state_e;

endpackage

// ==== hdl/pcx_request_latch.sv ====
// Latches the core's target region and PCX packet and decodes them into Wishbone address, selects and write enable
`timescale 1ns/1ps

module pcx_request_latch (
  input  logic                                   sys_clock_i,
  input  logic                                   sys_reset_i,
  input  logic                                   region_latch_i,
  input  logic                                   packet_latch_i,
  input  logic                                   second_beat_i,
  input  logic [bridge_pkg::region_width-1:0]    spc_req_i,
  input  logic [bridge_pkg::pcx_width-1:0]       spc_packetout_i,
  output logic [bridge_pkg::region_width-1:0]    region_o,
  output bridge_pkg::pcx_rq_e                    rq_type_o,
  output bridge_pkg::pcx_size_e                  size_o,
  output logic [1:0]                             thread_o,
  output logic                                   rnw_nc_o,
  output logic                                   addr_bit3_o,
  output logic [bridge_pkg::wb_addr_width-1:0]   wb_addr_o,
  output logic [bridge_pkg::wb_sel_width-1:0]    wb_sel_o,
  output logic                                   wb_we_o,
  output logic [bridge_pkg::wb_data_width-1:0]   wb_wdata_o
);

  logic [bridge_pkg::pcx_width-1:0]  packet_q;  // Request packet, held for the whole access
  logic [bridge_pkg::pcx_ad_top:0]   pcx_addr;  // 40-bit physical address
  logic [bridge_pkg::wb_sel_width-1:0] word_sel;

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      region_o <= '0;
    end else if (region_latch_i) begin
      region_o <= spc_req_i;  // One-hot target region
    end
  end

  always_ff @(posedge sys_clock_i) begin
    if (packet_latch_i) packet_q <= spc_packetout_i;
  end

  // Field slicing
  assign rq_type_o   = bridge_pkg::pcx_rq_e'(packet_q[bridge_pkg::pcx_rq_hi:bridge_pkg::pcx_rq_lo]);
  assign size_o      = bridge_pkg::pcx_size_e'(packet_q[bridge_pkg::pcx_sz_hi:bridge_pkg::pcx_sz_lo]);
  assign thread_o    = packet_q[bridge_pkg::pcx_th_hi:bridge_pkg::pcx_th_lo];
  assign rnw_nc_o    = packet_q[bridge_pkg::pcx_r_bit];
  assign pcx_addr    = packet_q[bridge_pkg::pcx_ad_hi:bridge_pkg::pcx_ad_lo];
  assign addr_bit3_o = pcx_addr[3];
  assign wb_wdata_o  = packet_q[bridge_pkg::pcx_da_hi:bridge_pkg::pcx_da_lo];

  // Region on top, doubleword aligned
  assign wb_addr_o = second_beat_i ?
    {region_o, {bridge_pkg::addr_pad_width{1'b0}}, pcx_addr[bridge_pkg::pcx_ad_top:4],
     bridge_pkg::beat2_offset} :
    {region_o, {bridge_pkg::addr_pad_width{1'b0}}, pcx_addr[bridge_pkg::pcx_ad_top:3], 3'b000};

  assign word_sel = bridge_pkg::sel_word << {pcx_addr[2], 2'b00};

  always_comb begin
    if (second_beat_i) begin
      wb_sel_o = bridge_pkg::sel_all;  // Second half of a quadword load
    end else if (rq_type_o == bridge_pkg::IMISS_RQ) begin
      wb_sel_o = word_sel;  // I/O fetch is a single 32-bit word
    end else begin
      case (size_o)
        bridge_pkg::SZ_1B:  wb_sel_o = bridge_pkg::sel_byte << pcx_addr[2:0];
        bridge_pkg::SZ_2B:  wb_sel_o = bridge_pkg::sel_half << {pcx_addr[2:1], 1'b0};
        bridge_pkg::SZ_4B:  wb_sel_o = word_sel;
        bridge_pkg::SZ_8B,
        bridge_pkg::SZ_16B: wb_sel_o = bridge_pkg::sel_all;
        default:            wb_sel_o = '0;  // Unsupported size, no lanes
      endcase
    end
  end

  // Fetches never write, invalid packet never writes
  assign wb_we_o = (rq_type_o != bridge_pkg::IMISS_RQ) && packet_q[bridge_pkg::pcx_vld_bit] &&
                   !rnw_nc_o;

endmodule

// ==== hdl/irq_tracker.sv ====
// Holds the last interrupt vector seen and flags changes that the sequencer forwards to the core
`timescale 1ns/1ps

module irq_tracker (
  input  logic                              sys_clock_i,
  input  logic                              sys_reset_i,
  input  logic                              sample_i,   // Sequencer idle and free
  input  logic                              accept_i,   // INT_RET packet sent
  input  logic [bridge_pkg::irq_width-1:0]  sys_interrupt_source_i,
  output logic                              changed_o,
  output logic                              pending_o,
  output logic [bridge_pkg::irq_width-1:0]  irq_source_o
);

  // Compare only while the sequencer is listening
  assign changed_o = sample_i && (sys_interrupt_source_i != irq_source_o);

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      irq_source_o <= '0;
      pending_o    <= 1'b0;
    end else if (changed_o) begin
      irq_source_o <= sys_interrupt_source_i;
      // A drop to zero is recorded but never forwarded
      pending_o    <= |sys_interrupt_source_i;
    end else if (accept_i) begin
      pending_o    <= 1'b0;
    end
  end

endmodule

// ==== hdl/cpx_packet_builder.sv ====
// Captures Wishbone read data and return fields and assembles the data, interrupt and wakeup CPX packets
`timescale 1ns/1ps

module cpx_packet_builder (
  input  logic                                  sys_clock_i,
  input  logic                                  sys_reset_i,
  input  logic                                  beat1_capture_i,
  input  logic                                  beat2_capture_i,
  input  bridge_pkg::pkt_kind_e                 pkt_kind_i,
  input  bridge_pkg::pcx_rq_e                   rq_type_i,
  input  logic [1:0]                            thread_i,
  input  logic                                  rnw_nc_i,
  input  logic [bridge_pkg::region_width-1:0]   region_i,
  input  logic                                  addr_bit3_i,
  input  logic [bridge_pkg::wb_data_width-1:0]  wbm_data_i,
  input  logic [bridge_pkg::irq_width-1:0]      irq_source_i,
  output logic [bridge_pkg::cpx_width-1:0]      spc_packetin_o
);

  bridge_pkg::cpx_rq_e                      ret_type_q;
  logic [1:0]                               thread_q;
  logic                                     nc_q;
  logic [1:0]                               pkt_id_q;
  logic [2*bridge_pkg::wb_data_width-1:0]   data_q;  // 128-bit load payload

  // Interrupt-style layout shared by INT_RET and wakeup
  function automatic logic [bridge_pkg::cpx_width-1:0] int_packet(
    input logic                             reset_not_int,
    input logic [bridge_pkg::irq_width-1:0] src,
    input logic [bridge_pkg::irq_width-1:0] last
  );
    return {1'b1, bridge_pkg::INT_RET, 3'b000, 1'b0, 2'b00, src, 111'b0,
            reset_not_int, 3'b000, 5'b00000, 2'b00, last};
  endfunction

  // Return header fields, taken at the first ack
  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      ret_type_q <= bridge_pkg::LOAD_RET;
      thread_q   <= 2'b00;
      nc_q       <= 1'b0;
      pkt_id_q   <= 2'b00;
    end else if (beat1_capture_i) begin
      case (rq_type_i)
        bridge_pkg::IMISS_RQ: ret_type_q <= bridge_pkg::IFILL_RET;
        bridge_pkg::STORE_RQ: ret_type_q <= bridge_pkg::ST_ACK;
        default:              ret_type_q <= bridge_pkg::LOAD_RET;
      endcase
      thread_q <= thread_i;
      nc_q     <= rnw_nc_i;
      pkt_id_q <= (region_i == bridge_pkg::io_region) ? 2'b01 : 2'b00;
    end
  end

  // Doubleword lands in the half picked by address bit 3
  always_ff @(posedge sys_clock_i) begin
    if (beat1_capture_i) begin
      data_q <= addr_bit3_i ? {{bridge_pkg::wb_data_width{1'b0}}, wbm_data_i}
                            : {wbm_data_i, {bridge_pkg::wb_data_width{1'b0}}};
    end else if (beat2_capture_i) begin
      data_q[bridge_pkg::wb_data_width-1:0] <= wbm_data_i;  // Lower half of a quadword
    end
  end

  always_comb begin
    case (pkt_kind_i)
      bridge_pkg::PKT_DATA:
        spc_packetin_o = {1'b1, ret_type_q, 3'b000, nc_q, thread_q, 2'b00, pkt_id_q, 2'b00,
                          data_q};
      bridge_pkg::PKT_INT:    spc_packetin_o = int_packet(1'b0, irq_source_i, irq_source_i);
      bridge_pkg::PKT_WAKEUP: spc_packetin_o = int_packet(1'b1, '0, bridge_pkg::wakeup_reset_type);
      default:                spc_packetin_o = '0;
    endcase
  end

endmodule

// ==== hdl/bridge_fsm.sv ====
// Bridge sequencer that drives the core handshake, the Wishbone master outputs and the packet strobes
`timescale 1ns/1ps

module bridge_fsm (
  input  logic                                  sys_clock_i,
  input  logic                                  sys_reset_i,
  input  logic [bridge_pkg::region_width-1:0]   spc_req_i,
  input  bridge_pkg::pcx_rq_e                   rq_type_i,
  input  bridge_pkg::pcx_size_e                 size_i,
  input  logic [bridge_pkg::region_width-1:0]   region_i,
  input  logic [bridge_pkg::wb_addr_width-1:0]  wb_addr_i,
  input  logic [bridge_pkg::wb_sel_width-1:0]   wb_sel_i,
  input  logic                                  wb_we_i,
  input  logic [bridge_pkg::wb_data_width-1:0]  wb_wdata_i,
  input  logic                                  wbm_ack_i,
  input  logic                                  irq_changed_i,
  input  logic                                  irq_pending_i,
  output logic [bridge_pkg::region_width-1:0]   spc_grant_o,
  output logic                                  spc_stallreq_o,
  output logic                                  spc_ready_o,
  output logic                                  region_latch_o,
  output logic                                  packet_latch_o,
  output logic                                  second_beat_o,
  output logic                                  beat1_capture_o,
  output logic                                  beat2_capture_o,
  output bridge_pkg::pkt_kind_e                 pkt_kind_o,
  output logic                                  irq_sample_o,
  output logic                                  irq_accept_o,
  output logic                                  wbm_cycle_o,
  output logic                                  wbm_strobe_o,
  output logic                                  wbm_we_o,
  output logic [bridge_pkg::wb_addr_width-1:0]  wbm_addr_o,
  output logic [bridge_pkg::wb_data_width-1:0]  wbm_data_o,
  output logic [bridge_pkg::wb_sel_width-1:0]   wbm_sel_o
);

  bridge_pkg::bridge_state_e state_q;
  logic req_any;     // Any region requested
  logic need_beat2;  // Quadword load takes two reads

  assign req_any    = |spc_req_i;
  assign need_beat2 = (rq_type_i == bridge_pkg::LOAD_RQ) && (size_i == bridge_pkg::SZ_16B);

  // Strobes to the datapath blocks
  assign region_latch_o  = (state_q == bridge_pkg::IDLE) && req_any;
  assign packet_latch_o  = (state_q == bridge_pkg::REQ_LATCHED);
  assign second_beat_o   = (state_q == bridge_pkg::ACCESS2_ISSUE);
  assign beat1_capture_o = (state_q == bridge_pkg::ACCESS1_WAIT) && wbm_ack_i;
  assign beat2_capture_o = (state_q == bridge_pkg::ACCESS2_WAIT) && wbm_ack_i;
  assign irq_sample_o    = (state_q == bridge_pkg::IDLE) && !req_any;  // Requests win
  assign irq_accept_o    = irq_sample_o && !irq_changed_i && irq_pending_i;

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      state_q        <= bridge_pkg::WAKEUP;
      spc_grant_o    <= '0;
      spc_stallreq_o <= 1'b0;
      spc_ready_o    <= 1'b0;
      pkt_kind_o     <= bridge_pkg::PKT_NONE;
      wbm_cycle_o    <= 1'b0;
      wbm_strobe_o   <= 1'b0;
      wbm_we_o       <= 1'b0;
      wbm_addr_o     <= '0;
      wbm_data_o     <= '0;
      wbm_sel_o      <= '0;
    end else begin
      spc_ready_o <= 1'b0;  // Ready is a single-cycle pulse
      pkt_kind_o  <= bridge_pkg::PKT_NONE;

      // Whole bus drops at the ack edge
      if (wbm_strobe_o && wbm_ack_i) begin
        wbm_cycle_o  <= 1'b0;
        wbm_strobe_o <= 1'b0;
        wbm_we_o     <= 1'b0;
        wbm_addr_o   <= '0;
        wbm_data_o   <= '0;
        wbm_sel_o    <= '0;
      end

      case (state_q)
        bridge_pkg::WAKEUP: begin
          spc_ready_o <= 1'b1;
          pkt_kind_o  <= bridge_pkg::PKT_WAKEUP;
          state_q     <= bridge_pkg::IDLE;
        end
        bridge_pkg::IDLE: begin
          if (req_any) begin
            spc_stallreq_o <= 1'b1;  // Region latched this edge
            state_q        <= bridge_pkg::REQ_LATCHED;
          end else if (irq_changed_i) begin
            spc_stallreq_o <= 1'b1;  // New vector stored, packet next cycle
          end else if (irq_pending_i) begin
            spc_stallreq_o <= 1'b1;
            spc_ready_o    <= 1'b1;
            pkt_kind_o     <= bridge_pkg::PKT_INT;
          end else begin
            spc_stallreq_o <= 1'b0;  // Nothing to do
          end
        end
        bridge_pkg::REQ_LATCHED: begin
          spc_grant_o <= region_i;  // Packet taken this edge
          state_q     <= bridge_pkg::PKT_LATCHED;
        end
        bridge_pkg::PKT_LATCHED, bridge_pkg::ACCESS2_ISSUE: begin
          spc_grant_o  <= '0;
          wbm_cycle_o  <= 1'b1;
          wbm_strobe_o <= 1'b1;
          wbm_we_o     <= wb_we_i;
          wbm_addr_o   <= wb_addr_i;
          wbm_data_o   <= wb_we_i ? wb_wdata_i : '0;  // Idle data on reads
          wbm_sel_o    <= wb_sel_i;
          state_q      <= (state_q == bridge_pkg::PKT_LATCHED) ? bridge_pkg::ACCESS1_WAIT
                                                               : bridge_pkg::ACCESS2_WAIT;
        end
        bridge_pkg::ACCESS1_WAIT: begin
          if (wbm_ack_i) begin
            state_q <= need_beat2 ? bridge_pkg::ACCESS2_ISSUE : bridge_pkg::PKT_READY;
          end
        end
        bridge_pkg::ACCESS2_WAIT: begin
          if (wbm_ack_i) state_q <= bridge_pkg::PKT_READY;
        end
        bridge_pkg::PKT_READY: begin
          spc_ready_o <= 1'b1;
          pkt_kind_o  <= bridge_pkg::PKT_DATA;
          state_q     <= bridge_pkg::IDLE;
        end
        default: state_q <= bridge_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/spc2wb_bridge.sv ====
// Top level of the OpenSPARC T1 PCX/CPX to 64-bit Wishbone master bridge, wiring the four blocks
`timescale 1ns/1ps

module spc2wb_bridge (
  input  logic                                  sys_clock_i,
  input  logic                                  sys_reset_i,
  input  logic [bridge_pkg::irq_width-1:0]      sys_interrupt_source_i,
  input  logic [bridge_pkg::region_width-1:0]   spc_req_i,
  input  logic [bridge_pkg::pcx_width-1:0]      spc_packetout_i,
  output logic [bridge_pkg::region_width-1:0]   spc_grant_o,
  output logic                                  spc_stallreq_o,
  output logic                                  spc_ready_o,
  output logic [bridge_pkg::cpx_width-1:0]      spc_packetin_o,
  output logic                                  wbm_cycle_o,
  output logic                                  wbm_strobe_o,
  output logic                                  wbm_we_o,
  output logic [bridge_pkg::wb_addr_width-1:0]  wbm_addr_o,
  output logic [bridge_pkg::wb_data_width-1:0]  wbm_data_o,
  output logic [bridge_pkg::wb_sel_width-1:0]   wbm_sel_o,
  input  logic                                  wbm_ack_i,
  input  logic [bridge_pkg::wb_data_width-1:0]  wbm_data_i
);

  // Sequencer strobes
  logic region_latch, packet_latch, second_beat;
  logic beat1_capture, beat2_capture;
  logic irq_sample, irq_accept;
  bridge_pkg::pkt_kind_e pkt_kind;

  // Decoded request
  logic [bridge_pkg::region_width-1:0]   region;
  bridge_pkg::pcx_rq_e                   rq_type;
  bridge_pkg::pcx_size_e                 size;
  logic [1:0]                            thread;
  logic                                  rnw_nc, addr_bit3, wb_we;
  logic [bridge_pkg::wb_addr_width-1:0]  wb_addr;
  logic [bridge_pkg::wb_sel_width-1:0]   wb_sel;
  logic [bridge_pkg::wb_data_width-1:0]  wb_wdata;

  // Interrupt state
  logic irq_changed, irq_pending;
  logic [bridge_pkg::irq_width-1:0] irq_source;

  pcx_request_latch u_latch (
    .sys_clock_i, .sys_reset_i,
    .region_latch_i(region_latch), .packet_latch_i(packet_latch), .second_beat_i(second_beat),
    .spc_req_i, .spc_packetout_i,
    .region_o(region), .rq_type_o(rq_type), .size_o(size), .thread_o(thread),
    .rnw_nc_o(rnw_nc), .addr_bit3_o(addr_bit3),
    .wb_addr_o(wb_addr), .wb_sel_o(wb_sel), .wb_we_o(wb_we), .wb_wdata_o(wb_wdata)
  );

  irq_tracker u_irq (
    .sys_clock_i, .sys_reset_i,
    .sample_i(irq_sample), .accept_i(irq_accept), .sys_interrupt_source_i,
    .changed_o(irq_changed), .pending_o(irq_pending), .irq_source_o(irq_source)
  );

  cpx_packet_builder u_builder (
    .sys_clock_i, .sys_reset_i,
    .beat1_capture_i(beat1_capture), .beat2_capture_i(beat2_capture), .pkt_kind_i(pkt_kind),
    .rq_type_i(rq_type), .thread_i(thread), .rnw_nc_i(rnw_nc), .region_i(region),
    .addr_bit3_i(addr_bit3), .wbm_data_i, .irq_source_i(irq_source),
    .spc_packetin_o
  );

  bridge_fsm u_fsm (
    .sys_clock_i, .sys_reset_i, .spc_req_i,
    .rq_type_i(rq_type), .size_i(size), .region_i(region),
    .wb_addr_i(wb_addr), .wb_sel_i(wb_sel), .wb_we_i(wb_we), .wb_wdata_i(wb_wdata),
    .wbm_ack_i, .irq_changed_i(irq_changed), .irq_pending_i(irq_pending),
    .spc_grant_o, .spc_stallreq_o, .spc_ready_o,
    .region_latch_o(region_latch), .packet_latch_o(packet_latch), .second_beat_o(second_beat),
    .beat1_capture_o(beat1_capture), .beat2_capture_o(beat2_capture), .pkt_kind_o(pkt_kind),
    .irq_sample_o(irq_sample), .irq_accept_o(irq_accept),
    .wbm_cycle_o, .wbm_strobe_o, .wbm_we_o, .wbm_addr_o, .wbm_data_o, .wbm_sel_o
  );

endmodule

// ==== bench/bridge_assert.sv ====
// Wishbone and core handshake protocol checks, bound into the bridge top level
`timescale 1ns/1ps

module bridge_assert (
  input logic                                  sys_clock_i,
  input logic                                  sys_reset_i,
  input logic [bridge_pkg::region_width-1:0]   spc_grant_i,
  input logic                                  spc_ready_i,
  input logic                                  wbm_cycle_i,
  input logic                                  wbm_strobe_i,
  input logic                                  wbm_we_i,
  input logic [bridge_pkg::wb_addr_width-1:0]  wbm_addr_i,
  input logic [bridge_pkg::wb_data_width-1:0]  wbm_data_i,
  input logic [bridge_pkg::wb_sel_width-1:0]   wbm_sel_i,
  input logic                                  wbm_ack_i
);

  int unsigned fail_count = 0;  // Read by the testbench at the end

  strobe_in_cycle: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    wbm_strobe_i |-> wbm_cycle_i) else begin
    fail_count++;
    $error("Wishbone strobe high outside a cycle");
  end

  // Master holds the whole bus until ack
  bus_stable: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (wbm_strobe_i && !wbm_ack_i) |=> (wbm_strobe_i && $stable(wbm_we_i) &&
    $stable(wbm_addr_i) && $stable(wbm_data_i) && $stable(wbm_sel_i))) else begin
    fail_count++;
    $error("Wishbone outputs changed before ack");
  end

  grant_pulse: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (|spc_grant_i) |=> (spc_grant_i == '0)) else begin
    fail_count++;
    $error("grant held longer than one cycle");
  end

  ready_pulse: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    spc_ready_i |=> !spc_ready_i) else begin
    fail_count++;
    $error("ready held longer than one cycle");
  end

  grant_onehot: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    $onehot0(spc_grant_i)) else begin
    fail_count++;
    $error("grant has more than one region set");
  end

endmodule

bind spc2wb_bridge bridge_assert u_assert (
  .sys_clock_i(sys_clock_i), .sys_reset_i(sys_reset_i),
  .spc_grant_i(spc_grant_o), .spc_ready_i(spc_ready_o),
  .wbm_cycle_i(wbm_cycle_o), .wbm_strobe_i(wbm_strobe_o), .wbm_we_i(wbm_we_o),
  .wbm_addr_i(wbm_addr_o), .wbm_data_i(wbm_data_o), .wbm_sel_i(wbm_sel_o),
  .wbm_ack_i(wbm_ack_i)
);

// ==== bench/bridge_tb.sv ====
// Testbench for the core to Wishbone bridge, with a core request driver and a Wishbone memory model
`timescale 1ns/1ps

module bridge_tb;

  typedef logic [bridge_pkg::cpx_width-1:0] check_t;  // Widest compared value

  localparam int grant_limit = 20;
  localparam int ready_limit = 40;  // Two accesses at worst ack delay
  localparam logic [63:0] data_mask = 64'h5a5a_0000_c3c3_0000;

  logic sys_clock = 1'b0;
  logic sys_reset;
  logic [bridge_pkg::irq_width-1:0] irq_source;
  logic [bridge_pkg::region_width-1:0] spc_req, spc_grant;
  logic [bridge_pkg::pcx_width-1:0] spc_packetout;
  logic [bridge_pkg::cpx_width-1:0] spc_packetin;
  logic spc_stallreq, spc_ready;
  logic wbm_cycle, wbm_strobe, wbm_we, wbm_ack;
  logic [63:0] wbm_addr, wbm_wdata, wbm_rdata;
  logic [7:0] wbm_sel;

  logic [31:0] lfsr = 32'h7180d1b5;
  int errors = 0;
  int timeouts = 0;

  // Accesses seen by the memory model in arrival order
  logic [63:0] acc_addr[$];
  logic [63:0] acc_wdata[$];
  logic [7:0]  acc_sel[$];
  logic        acc_we[$];
  logic        acc_open = 1'b0;
  int          ack_delay;

  spc2wb_bridge DUT (
    .sys_clock_i(sys_clock), .sys_reset_i(sys_reset), .sys_interrupt_source_i(irq_source),
    .spc_req_i(spc_req), .spc_packetout_i(spc_packetout), .spc_grant_o(spc_grant),
    .spc_stallreq_o(spc_stallreq), .spc_ready_o(spc_ready), .spc_packetin_o(spc_packetin),
    .wbm_cycle_o(wbm_cycle), .wbm_strobe_o(wbm_strobe), .wbm_we_o(wbm_we),
    .wbm_addr_o(wbm_addr), .wbm_data_o(wbm_wdata), .wbm_sel_o(wbm_sel),
    .wbm_ack_i(wbm_ack), .wbm_data_i(wbm_rdata)
  );

  always #4 sys_clock = ~sys_clock;  // 8 ns period

  task automatic next_edge();
    @(posedge sys_clock);
    #1;  // Drive and sample off the edge
  endtask

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};  // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_value(input string name, input check_t got, input check_t exp);
    assert (got === exp) else begin
      errors++;
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [bridge_pkg::pcx_width-1:0] make_pcx(input logic [4:0] rq,
      input logic r, input logic [1:0] th, input logic [2:0] sz, input logic [39:0] addr,
      input logic [63:0] data);
    return {1'b1, rq, r, 3'b000, th, 5'b00000, sz, addr, data};
  endfunction

  function automatic logic [63:0] bus_addr(input logic [4:0] region, input logic [39:0] addr);
    return {region, 19'b0, addr[39:3], 3'b000};  // Region prefix on a doubleword address
  endfunction

  function automatic logic [7:0] expected_sel(input logic [2:0] sz, input logic [39:0] addr);
    case (sz)
      3'b000:  return 8'h01 << addr[2:0];
      3'b001:  return 8'h03 << (addr[2:1] * 2);
      3'b010:  return 8'h0f << (addr[2] * 4);
      default: return 8'hff;
    endcase
  endfunction

  function automatic check_t data_packet(input logic [3:0] ret, input logic nc,
      input logic [1:0] th, input logic [1:0] id, input logic [127:0] data);
    return {1'b1, ret, 3'b000, nc, th, 2'b00, id, 2'b00, data};
  endfunction

  function automatic check_t interrupt_packet(input logic rst, input logic [5:0] src,
      input logic [5:0] last);
    return {1'b1, 4'b0111, 6'b0, src, 111'b0, rst, 3'b000, 5'b0, 2'b00, last};
  endfunction

  // Looks from the next edge on so an old pulse is not taken twice
  task automatic wait_ready(output logic seen);
    int cycles;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < ready_limit) begin
      next_edge();
      cycles++;
      seen = spc_ready;
    end
    if (!seen) begin
      timeouts++;
      $display("no ready pulse from the bridge within the timeout");
    end
  endtask

  // Core side holds request and packet until grant
  task automatic transfer(input logic [4:0] region, input logic [123:0] packet);
    int cycles;
    logic seen;
    spc_req = region;
    spc_packetout = packet;
    cycles = 0;
    while (spc_grant == '0 && cycles < grant_limit) begin
      next_edge();
      cycles++;
    end
    if (spc_grant == '0) begin
      timeouts++;
      $display("no grant for region %b within the timeout", region);
    end else begin
      check_value("spc_grant_o", check_t'(spc_grant), check_t'(region));
      check_value("spc_stallreq_o", check_t'(spc_stallreq), check_t'(1'b1));
    end
    spc_req = '0;
    spc_packetout = '0;
    wait_ready(seen);
  endtask

  task automatic check_access(input logic exp_we, input logic [63:0] exp_addr,
      input logic [7:0] exp_sel, input logic [63:0] exp_wdata);
    assert (acc_addr.size() != 0) else begin
      errors++;
      $display("a Wishbone access was expected but the memory model saw none");
    end
    if (acc_addr.size() != 0) begin
      check_value("wbm_we_o", check_t'(acc_we.pop_front()), check_t'(exp_we));
      check_value("wbm_addr_o", check_t'(acc_addr.pop_front()), check_t'(exp_addr));
      check_value("wbm_sel_o", check_t'(acc_sel.pop_front()), check_t'(exp_sel));
      check_value("wbm_data_o", check_t'(acc_wdata.pop_front()), check_t'(exp_wdata));
    end
  endtask

  task automatic check_packet(input check_t exp);
    check_value("spc_packetin_o", spc_packetin, exp);
    check_value("extra Wishbone accesses", check_t'(acc_addr.size()), '0);
  endtask

  // Memory model acks after 0 to 3 cycles
  always @(posedge sys_clock) begin
    logic [63:0] rnd;
    #1;
    if (wbm_ack) begin
      wbm_ack   = 1'b0;  // Taken by the DUT at this edge
      wbm_rdata = '0;
      acc_open  = 1'b0;
    end else if (wbm_strobe && !acc_open) begin
      acc_open = 1'b1;
      acc_addr.push_back(wbm_addr);
      acc_wdata.push_back(wbm_wdata);
      acc_sel.push_back(wbm_sel);
      acc_we.push_back(wbm_we);
      draw(2, rnd);
      ack_delay = int'(rnd[1:0]);
    end else if (acc_open) begin
      ack_delay--;
    end
    if (acc_open && !wbm_ack && ack_delay == 0) begin
      wbm_ack   = 1'b1;
      wbm_rdata = wbm_we ? '0 : (wbm_addr ^ data_mask);  // Reads return a tagged address
    end
  end

  initial begin
    logic [63:0] rnd, ba, ba2, rd1, rd2;
    logic [39:0] addr;
    logic [1:0]  th;
    logic [4:0]  region;
    logic        seen;
    sys_reset = 1'b1;
    irq_source = '0;
    spc_req = '0;
    spc_packetout = '0;
    wbm_ack = 1'b0;
    wbm_rdata = '0;
    repeat (3) next_edge();
    check_value("control outputs in reset",
                check_t'({spc_grant, spc_stallreq, spc_ready, wbm_cycle, wbm_strobe, wbm_we}),
                '0);
    sys_reset = 1'b0;

    wait_ready(seen);  // Wakeup right after reset
    check_value("spc_packetin_o", spc_packetin, interrupt_packet(1'b1, 6'd0, 6'b000001));

    for (int sz = 0; sz < 4; sz++) begin  // 1, 2, 4 and 8 byte stores
      for (int k = 0; k < 3; k++) begin
        draw(40, rnd);
        addr = rnd[39:0];
        draw(2, rnd);
        th = rnd[1:0];
        draw(64, rnd);
        region = 5'b00001 << k;
        transfer(region, make_pcx(5'b00001, 1'b0, th, sz[2:0], addr, rnd));
        check_access(1'b1, bus_addr(region, addr), expected_sel(sz[2:0], addr), rnd);
        check_packet(data_packet(4'b0100, 1'b0, th, 2'b00, '0));
      end
    end

    for (int b3 = 0; b3 < 2; b3++) begin  // 8-byte loads into both halves
      draw(40, rnd);
      addr = {rnd[39:4], b3[0], rnd[2:0]};
      draw(2, rnd);
      th = rnd[1:0];
      region = 5'b00100;
      ba = bus_addr(region, addr);
      rd1 = ba ^ data_mask;
      transfer(region, make_pcx(5'b00000, 1'b1, th, 3'b011, addr, '0));
      check_access(1'b0, ba, 8'hff, '0);
      check_packet(data_packet(4'b0000, 1'b1, th, 2'b00, b3 ? {64'b0, rd1} : {rd1, 64'b0}));
    end

    draw(40, rnd);  // 16-byte load in two reads
    addr = {rnd[39:4], 4'b0000};
    th = 2'b10;
    region = 5'b01000;
    ba = bus_addr(region, addr);
    ba2 = {region, 19'b0, addr[39:4], 4'b1000};
    rd1 = ba ^ data_mask;
    rd2 = ba2 ^ data_mask;
    transfer(region, make_pcx(5'b00000, 1'b1, th, 3'b111, addr, '0));
    check_access(1'b0, ba, 8'hff, '0);
    check_access(1'b0, ba2, 8'hff, '0);
    check_packet(data_packet(4'b0000, 1'b1, th, 2'b00, {rd1, rd2}));

    for (int w = 0; w < 2; w++) begin  // I/O fetch ignores the size field
      draw(40, rnd);
      addr = {rnd[39:4], w[0], w[0], rnd[1:0]};
      th = 2'b01;
      region = 5'b10000;
      ba = bus_addr(region, addr);
      rd1 = ba ^ data_mask;
      transfer(region, make_pcx(5'b10000, 1'b1, th, 3'b000, addr, '0));
      check_access(1'b0, ba, w ? 8'hf0 : 8'h0f, '0);
      check_packet(data_packet(4'b0001, 1'b1, th, 2'b01, w ? {64'b0, rd1} : {rd1, 64'b0}));
    end

    irq_source = 6'h2a;  // Nonzero vector change
    wait_ready(seen);
    check_value("spc_packetin_o", spc_packetin, interrupt_packet(1'b0, 6'h2a, 6'h2a));
    irq_source = '0;  // Stored silently
    repeat (10) begin
      next_edge();
      check_value("spc_ready_o", check_t'(spc_ready), '0);
    end
    check_value("spc_stallreq_o", check_t'(spc_stallreq), '0);  // Released when idle

    $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, DUT.u_assert.fail_count);
    if (errors == 0 && timeouts == 0 && DUT.u_assert.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hdl/bridge_pkg.sv
hdl/pcx_request_latch.sv
hdl/irq_tracker.sv
hdl/cpx_packet_builder.sv
hdl/bridge_fsm.sv
hdl/spc2wb_bridge.sv
bench/bridge_assert.sv
bench/bridge_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 --top-module bridge_tb -f list.f -o bridge_sim

output=$(./obj_dir/bridge_sim +verilator+error+limit+1000) || true
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
  exit 0
else
  exit 1
fi
